// ==== Makefile ====
# Verilator build and run of the botInput testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --top-module botInputTb -f botInput.f -o simv
	./obj_dir/simv | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "test did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== botInput.f ====
+incdir+sim
hdl/botInputPkg.sv
hdl/botFifo.sv
hdl/fifoScheduler.sv
hdl/swapExpander.sv
hdl/inputConfig.sv
hdl/botInput.sv
sim/botInputTb.sv

// ==== hdl/botFifo.sv ====
`timescale 1ns/1ps

module botFifo #(
    parameter int fifoDepthLog2 = 5
) (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    push,
    input  botInputPkg::fifoEntryT  pushData,
    input  logic                    pop,
    output botInputPkg::fifoEntryT  headData,
    output logic                    empty,
    output logic                    full,
    output logic [fifoDepthLog2:0]  fillCount
);
    import botInputPkg::*;

    localparam int depth = 1 << fifoDepthLog2;

    fifoEntryT                mem [depth];
    logic [fifoDepthLog2-1:0] wrPtr;
    logic [fifoDepthLog2-1:0] rdPtr;
    logic                     doPush;
    logic                     doPop;

    assign empty = (fillCount == '0);
    assign full  = fillCount[fifoDepthLog2];   // count == depth
    assign doPush = push && !full;             // dropped when full
    assign doPop  = pop && !empty;

    // first word fall through
    assign headData = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            fillCount <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (doPush && !doPop) begin
                fillCount <= fillCount + 1'b1;
            end else if (doPop && !doPush) begin
                fillCount <= fillCount - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

endmodule

// ==== hdl/botInput.sv ====
`timescale 1ns/1ps

module botInput #(
    parameter int fifoDepthLog2 = 5
) (
    input  logic                      clk,
    input  logic                      rstN,
    input  botInputPkg::botT          botA,
    input  botInputPkg::botT          botC,
    input  botInputPkg::botIndexT     botIndex,
    input  logic                      validA,
    input  logic                      validB,
    input  logic                      validC,
    input  logic                      validD,
    input  logic                      dataRequested,
    input  logic                      cfgReq,
    input  botInputPkg::cfgAddrT      cfgAddr,
    input  logic [7:0]                cfgData,
    output logic                      full,
    output logic                      almostFull,
    output logic                      botOutAvailable,
    output botInputPkg::botT          botOut,
    output botInputPkg::botIndexT     botOutIndex,
    output botInputPkg::outSubIndexT  botOutSubIndex,
    output logic                      cfgAck
);
    import botInputPkg::*;

    fifoEntryT              entryAB;
    fifoEntryT              entryCD;
    fifoEntryT              headAB;
    fifoEntryT              headCD;
    fifoEntryT              chosenEntry;
    logic                   emptyAB;
    logic                   emptyCD;
    logic                   fullAB;
    logic                   fullCD;
    logic                   popAB;
    logic                   popCD;
    logic [fifoDepthLog2:0] countAB;
    logic [fifoDepthLog2:0] countCD;
    logic                   schedAvailable;
    logic                   chosenCD;
    logic                   take;
    logic                   expSwapped;
    logic                   outFromCD;
    cfgRegsT                cfgRegs;

    assign entryAB = '{bot: botA, index: botIndex, wantPlain: validA, wantSwap: validB};
    assign entryCD = '{bot: botC, index: botIndex, wantPlain: validC, wantSwap: validD};

    assign full       = fullAB || fullCD;
    assign almostFull = (8'(countAB) >= cfgRegs.almostFullLevel) ||
                        (8'(countCD) >= cfgRegs.almostFullLevel);

    botFifo #(.fifoDepthLog2(fifoDepthLog2)) fifoAB_i (
        .clk(clk), .rstN(rstN),
        .push(validA || validB), .pushData(entryAB), .pop(popAB),
        .headData(headAB), .empty(emptyAB), .full(fullAB), .fillCount(countAB)
    );

    botFifo #(.fifoDepthLog2(fifoDepthLog2)) fifoCD_i (
        .clk(clk), .rstN(rstN),
        .push(validC || validD), .pushData(entryCD), .pop(popCD),
        .headData(headCD), .empty(emptyCD), .full(fullCD), .fillCount(countCD)
    );

    fifoScheduler #(.fifoDepthLog2(fifoDepthLog2)) scheduler_i (
        .clk(clk), .rstN(rstN),
        .emptyAB(emptyAB), .emptyCD(emptyCD), .headAB(headAB), .headCD(headCD),
        .countAB(countAB), .countCD(countCD), .schedMode(cfgRegs.schedMode),
        .take(take), .popAB(popAB), .popCD(popCD), .available(schedAvailable),
        .chosenEntry(chosenEntry), .chosenCD(chosenCD)
    );

    swapExpander expander_i (
        .clk(clk), .rstN(rstN),
        .entryIn(chosenEntry), .available(schedAvailable), .dataRequested(dataRequested),
        .take(take), .botOut(botOut), .botOutAvailable(botOutAvailable),
        .swapped(expSwapped)
    );

    inputConfig #(.fifoDepthLog2(fifoDepthLog2)) config_i (
        .clk(clk), .rstN(rstN),
        .cfgReq(cfgReq), .cfgAddr(cfgAddr), .cfgData(cfgData),
        .cfgAck(cfgAck), .cfgRegs(cfgRegs)
    );

    // index and source follow the entry held in the expander
    always_ff @(posedge clk) begin
        if (take) begin
            botOutIndex <= chosenEntry.index;
            outFromCD   <= chosenCD;
        end
    end

    assign botOutSubIndex = '{fromCD: outFromCD, swapped: expSwapped};

endmodule

// ==== hdl/botInputPkg.sv ====
package botInputPkg;

    typedef logic [127:0] botT;      // truth table of a seven-variable function
    typedef logic [11:0] botIndexT;

    // one queued item of 142 bits
    typedef struct packed {
        botT      bot;
        botIndexT index;
        logic     wantPlain;
        logic     wantSwap;    // variables 5 and 6 exchanged
    } fifoEntryT;

    typedef enum logic {
        schedBalanced  = 1'b0,
        schedAlternate = 1'b1
    } schedModeT;

    typedef enum logic {
        cfgAlmostFull = 1'b0,
        cfgSchedMode  = 1'b1
    } cfgAddrT;

    typedef struct packed {
        logic [7:0] almostFullLevel;
        schedModeT  schedMode;
    } cfgRegsT;

    typedef struct packed {
        logic fromCD;
        logic swapped;
    } outSubIndexT;

endpackage

// ==== hdl/fifoScheduler.sv ====
`timescale 1ns/1ps

module fifoScheduler #(
    parameter int fifoDepthLog2 = 5
) (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    emptyAB,
    input  logic                    emptyCD,
    input  botInputPkg::fifoEntryT  headAB,
    input  botInputPkg::fifoEntryT  headCD,
    input  logic [fifoDepthLog2:0]  countAB,
    input  logic [fifoDepthLog2:0]  countCD,
    input  botInputPkg::schedModeT  schedMode,
    input  logic                    take,
    output logic                    popAB,
    output logic                    popCD,
    output logic                    available,
    output botInputPkg::fifoEntryT  chosenEntry,
    output logic                    chosenCD
);
    import botInputPkg::*;

    logic lastPick;   // 1 means CD
    logic prevPick;
    logic grab;

    assign available = !emptyAB || !emptyCD;
    assign grab      = take && available;

    always_comb begin
        chosenCD = 1'b0;
        if (emptyAB && !emptyCD) begin
            chosenCD = 1'b1;
        end else if (!emptyAB && !emptyCD) begin
            if (schedMode == schedAlternate) begin
                chosenCD = !lastPick;
            end else if (lastPick == prevPick) begin
                chosenCD = !lastPick;   // no third pick in a row
            end else begin
                chosenCD = (countCD >= countAB);   // fuller one wins ties to CD
            end
        end
    end

    assign chosenEntry = chosenCD ? headCD : headAB;

    // pops only ever reach a non-empty fifo
    assign popAB = grab && !chosenCD;
    assign popCD = grab && chosenCD;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            lastPick <= 1'b0;
            prevPick <= 1'b0;
        end else if (grab) begin
            prevPick <= lastPick;
            lastPick <= chosenCD;
        end
    end

endmodule

// ==== hdl/inputConfig.sv ====
`timescale 1ns/1ps

module inputConfig #(
    parameter int fifoDepthLog2 = 5
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  cfgReq,
    input  botInputPkg::cfgAddrT  cfgAddr,
    input  logic [7:0]            cfgData,
    output logic                  cfgAck,
    output botInputPkg::cfgRegsT  cfgRegs
);
    import botInputPkg::*;

    localparam int depth = 1 << fifoDepthLog2;

    typedef enum logic {
        stIdle  = 1'b0,
        stAcked = 1'b1
    } cfgStateT;

    cfgStateT state;

    assign cfgAck = (state == stAcked);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state                   <= stIdle;
            cfgRegs.almostFullLevel <= 8'(depth - 4);
            cfgRegs.schedMode       <= schedBalanced;
        end else begin
            case (state)
                stIdle: if (cfgReq) begin
                    state <= stAcked;   // one write per request
                    if (cfgAddr == cfgAlmostFull) begin
                        cfgRegs.almostFullLevel <= cfgData;
                    end else begin
                        cfgRegs.schedMode <= schedModeT'(cfgData[0]);
                    end
                end
                stAcked: if (!cfgReq) begin
                    state <= stIdle;
                end
                default: state <= stIdle;
            endcase
        end
    end

endmodule

// ==== hdl/swapExpander.sv ====
`timescale 1ns/1ps

module swapExpander (
    input  logic                    clk,
    input  logic                    rstN,
    input  botInputPkg::fifoEntryT  entryIn,
    input  logic                    available,
    input  logic                    dataRequested,
    output logic                    take,
    output botInputPkg::botT        botOut,
    output logic                    botOutAvailable,
    output logic                    swapped
);
    import botInputPkg::*;

    botT  curBot;
    logic pendPlain;
    logic pendSwap;
    logic transfer;
    logic lastLeaving;

    assign botOutAvailable = pendPlain || pendSwap;
    assign transfer        = botOutAvailable && dataRequested;
    // one variant left and it goes out now
    assign lastLeaving     = transfer && !(pendPlain && pendSwap);
    assign take            = available && (!botOutAvailable || lastLeaving);

    // blocks 1 and 2 trade places for the swapped variant
    assign botOut = {curBot[127:96],
                     pendSwap ? curBot[63:32] : curBot[95:64],
                     pendSwap ? curBot[95:64] : curBot[63:32],
                     curBot[31:0]};
    assign swapped = pendSwap;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pendPlain <= 1'b0;
            pendSwap  <= 1'b0;
        end else if (take) begin
            pendPlain <= entryIn.wantPlain;
            pendSwap  <= entryIn.wantSwap;
        end else if (transfer) begin
            if (pendSwap) begin
                pendSwap <= 1'b0;    // swapped goes first
            end else begin
                pendPlain <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            curBot <= entryIn.bot;
        end
    end

endmodule

// ==== sim/botInputVectors.svh ====
`ifndef BOT_INPUT_VECTORS_SVH
`define BOT_INPUT_VECTORS_SVH

typedef struct {
    string    name;
    botT      botA;
    botT      botC;
    botIndexT index;
    logic [3:0] valids;
    logic     stall;
} vecRowT;

localparam int numRows     = 40;
localparam int randomStart = 4;   // rows from here on see random stalls

// each row gives name, seed word, index, valid flags {A,B,C,D} and stall
// expandBot in the testbench turns the seed word into botA and botC
task automatic fillTable();
    // directed rows for AB and CD
    addRow("abBoth",  32'h1234_5678, 12'h001, 4'b1100, 1'b0);
    addRow("abPlain", 32'h0bad_cafe, 12'h002, 4'b1000, 1'b0);
    addRow("abSwap",  32'h7777_0001, 12'h003, 4'b0100, 1'b0);
    addRow("cdBoth",  32'h600d_f00d, 12'h004, 4'b0011, 1'b1);
    // mixed traffic
    addRow("rnd04", 32'h0000_0104, 12'h104, 4'b1111, 1'b0);
    addRow("rnd05", 32'h0000_0105, 12'h105, 4'b1010, 1'b0);
    addRow("rnd06", 32'h0000_0106, 12'h106, 4'b0101, 1'b0);
    addRow("rnd07", 32'h0000_0107, 12'h107, 4'b0000, 1'b0);
    addRow("rnd08", 32'h0000_0108, 12'h108, 4'b1001, 1'b1);
    addRow("rnd09", 32'h0000_0109, 12'h109, 4'b0110, 1'b0);
    addRow("rnd10", 32'h0000_0110, 12'h110, 4'b1111, 1'b0);
    addRow("rnd11", 32'h0000_0111, 12'h111, 4'b1100, 1'b0);
    addRow("rnd12", 32'h0000_0112, 12'h112, 4'b0011, 1'b0);
    addRow("rnd13", 32'h0000_0113, 12'h113, 4'b1011, 1'b1);
    addRow("rnd14", 32'h0000_0114, 12'h114, 4'b0111, 1'b0);
    addRow("rnd15", 32'h0000_0115, 12'h115, 4'b1000, 1'b0);
    addRow("rnd16", 32'h0000_0116, 12'h116, 4'b0010, 1'b0);
    addRow("rnd17", 32'h0000_0117, 12'h117, 4'b1111, 1'b0);
    addRow("rnd18", 32'h0000_0118, 12'h118, 4'b0100, 1'b0);
    addRow("rnd19", 32'h0000_0119, 12'h119, 4'b0001, 1'b1);
    addRow("rnd20", 32'h0000_0120, 12'h120, 4'b1101, 1'b0);
    addRow("rnd21", 32'h0000_0121, 12'h121, 4'b1110, 1'b0);
    addRow("rnd22", 32'h0000_0122, 12'h122, 4'b1111, 1'b0);
    addRow("rnd23", 32'h0000_0123, 12'h123, 4'b0000, 1'b0);
    addRow("rnd24", 32'h0000_0124, 12'h124, 4'b1010, 1'b0);
    addRow("rnd25", 32'h0000_0125, 12'h125, 4'b0101, 1'b0);
    addRow("rnd26", 32'h0000_0126, 12'h126, 4'b1111, 1'b1);
    addRow("rnd27", 32'h0000_0127, 12'h127, 4'b1100, 1'b0);
    addRow("rnd28", 32'h0000_0128, 12'h128, 4'b0011, 1'b0);
    addRow("rnd29", 32'h0000_0129, 12'h129, 4'b1001, 1'b0);
    addRow("rnd30", 32'h0000_0130, 12'h130, 4'b0110, 1'b0);
    addRow("rnd31", 32'h0000_0131, 12'h131, 4'b1111, 1'b0);
    addRow("rnd32", 32'h0000_0132, 12'h132, 4'b1000, 1'b1);
    addRow("rnd33", 32'h0000_0133, 12'h133, 4'b0010, 1'b0);
    addRow("rnd34", 32'h0000_0134, 12'h134, 4'b0111, 1'b0);
    addRow("rnd35", 32'h0000_0135, 12'h135, 4'b1011, 1'b0);
    addRow("rnd36", 32'h0000_0136, 12'h136, 4'b1111, 1'b0);
    addRow("rnd37", 32'h0000_0137, 12'h137, 4'b0100, 1'b0);
    addRow("rnd38", 32'h0000_0138, 12'h138, 4'b0001, 1'b0);
    addRow("rnd39", 32'h0000_0139, 12'h139, 4'b1111, 1'b0);
endtask

`endif

// ==== sim/botInputTb.sv ====
`timescale 1ns/1ps

module botInputTb;
    import botInputPkg::*;

    localparam int fifoDepthLog2 = 5;
    localparam int depth         = 1 << fifoDepthLog2;

    `include "botInputVectors.svh"

    // table rows plus the entries of the fill and alternation tests
    localparam int cycleLimit = 8 * (numRows + depth + 1 + 6) + 200;

    typedef struct packed {
        botT      bot;
        botIndexT index;
        logic     swapped;
    } expectT;

    logic        clk;
    logic        rstN;
    botT         botA;
    botT         botC;
    botIndexT    botIndex;
    logic        validA;
    logic        validB;
    logic        validC;
    logic        validD;
    logic        dataRequested;
    logic        cfgReq;
    cfgAddrT     cfgAddr;
    logic [7:0]  cfgData;
    logic        full;
    logic        almostFull;
    logic        botOutAvailable;
    botT         botOut;
    botIndexT    botOutIndex;
    outSubIndexT botOutSubIndex;
    logic        cfgAck;

    vecRowT      vecTable[$];
    expectT      expAB[$];
    expectT      expCD[$];
    logic        altSeq[$];
    string       curTest = "reset";
    int          errorCount = 0;
    int          cycles = 0;
    logic [31:0] rngState = 32'd77206;
    logic        randomStalls = 1'b0;
    logic        holdStall = 1'b0;
    logic        altRecord = 1'b0;
    logic        heldValid = 1'b0;
    botT         heldBot;

    botInput #(.fifoDepthLog2(fifoDepthLog2)) dut_i (
        .clk(clk), .rstN(rstN),
        .botA(botA), .botC(botC), .botIndex(botIndex),
        .validA(validA), .validB(validB), .validC(validC), .validD(validD),
        .dataRequested(dataRequested),
        .cfgReq(cfgReq), .cfgAddr(cfgAddr), .cfgData(cfgData),
        .full(full), .almostFull(almostFull),
        .botOutAvailable(botOutAvailable), .botOut(botOut),
        .botOutIndex(botOutIndex), .botOutSubIndex(botOutSubIndex),
        .cfgAck(cfgAck)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic botT expandBot(input logic [31:0] w);
        return {w, ~w, w + 32'd1, w ^ 32'hffff_0000};   // four distinct blocks
    endfunction

    // variables 5 and 6 swapped
    function automatic botT swapBlocks(input botT b);
        return {b[127:96], b[63:32], b[95:64], b[31:0]};
    endfunction

    function automatic logic consumerReady(input logic stallNow);
        rngState = xorshift(rngState);
        return !(stallNow || (randomStalls && rngState[1:0] == 2'b00));
    endfunction

    task automatic addRow(input string name, input logic [31:0] seed, input botIndexT idx,
                          input logic [3:0] valids, input logic stall);
        vecRowT row;
        row.name   = name;
        row.botA   = expandBot(seed);
        row.botC   = expandBot(seed ^ 32'h5a5a_0f0f);
        row.index  = idx;
        row.valids = valids;
        row.stall  = stall;
        vecTable.push_back(row);
    endtask

    task automatic checkValue(input string what, input logic [127:0] expVal,
                              input logic [127:0] actVal);
        if (expVal !== actVal) begin
            errorCount++;
            $display("error %s %s: expected %h, actual %h", curTest, what, expVal, actVal);
        end
    endtask

    task automatic queueEntry(input botT bot, input botIndexT idx, input logic wantPlain,
                              input logic wantSwap, input logic toCD);
        expectT e;
        if (wantSwap) begin
            e = '{bot: swapBlocks(bot), index: idx, swapped: 1'b1};
            if (toCD) expCD.push_back(e);
            else expAB.push_back(e);
        end
        if (wantPlain) begin
            e = '{bot: bot, index: idx, swapped: 1'b0};
            if (toCD) expCD.push_back(e);
            else expAB.push_back(e);
        end
    endtask

    // one clock, then idle producer inputs
    task automatic stepCycle();
        @(posedge clk);
        #10;
        validA = 1'b0;
        validB = 1'b0;
        validC = 1'b0;
        validD = 1'b0;
        dataRequested = consumerReady(holdStall);
    endtask

    task automatic driveRow(input vecRowT row);
        while (full) stepCycle();   // producers wait on full
        curTest  = row.name;
        botA     = row.botA;
        botC     = row.botC;
        botIndex = row.index;
        {validA, validB, validC, validD} = row.valids;
        dataRequested = consumerReady(row.stall);
        queueEntry(row.botA, row.index, row.valids[3], row.valids[2], 1'b0);
        queueEntry(row.botC, row.index, row.valids[1], row.valids[0], 1'b1);
        stepCycle();
    endtask

    task automatic waitDrained();
        while (expAB.size() != 0 || expCD.size() != 0 || botOutAvailable) stepCycle();
    endtask

    task automatic cfgWrite(input cfgAddrT addr, input logic [7:0] data);
        cfgReq  = 1'b1;
        cfgAddr = addr;
        cfgData = data;
        stepCycle();
        checkValue("cfgAck rise", 128'(1'b1), 128'(cfgAck));
        cfgReq = 1'b0;
        stepCycle();
        checkValue("cfgAck fall", 128'(1'b0), 128'(cfgAck));
    endtask

    // scoreboard sampled mid cycle
    always @(negedge clk) begin
        expectT e;
        if (rstN) begin
            if (heldValid && botOutAvailable && botOut !== heldBot) begin
                errorCount++;
                $display("error %s stall: expected %h, actual %h", curTest, heldBot, botOut);
            end
            if (botOutAvailable && dataRequested) begin
                if (botOutSubIndex.fromCD ? expCD.size() == 0 : expAB.size() == 0) begin
                    errorCount++;
                    $display("%s: output arrived that no entry asked for", curTest);
                end else begin
                    e = botOutSubIndex.fromCD ? expCD.pop_front() : expAB.pop_front();
                    checkValue("bot", e.bot, botOut);
                    checkValue("index", 128'(e.index), 128'(botOutIndex));
                    checkValue("swapped", 128'(e.swapped), 128'(botOutSubIndex.swapped));
                end
                if (altRecord && botOutSubIndex.swapped) altSeq.push_back(botOutSubIndex.fromCD);
            end
            heldValid = botOutAvailable && !dataRequested;
            heldBot   = botOut;
        end
    end

    initial begin
        rstN          = 1'b0;
        botA          = '0;
        botC          = '0;
        botIndex      = '0;
        validA        = 1'b0;
        validB        = 1'b0;
        validC        = 1'b0;
        validD        = 1'b0;
        dataRequested = 1'b1;
        cfgReq        = 1'b0;
        cfgAddr       = cfgAlmostFull;
        cfgData       = '0;
        fillTable();
        if (vecTable.size() != numRows) begin
            errorCount++;
            $display("stimulus table holds %0d rows instead of %0d", vecTable.size(), numRows);
        end
        repeat (2) @(posedge clk);
        #10;
        rstN = 1'b1;

        checkValue("botOutAvailable", 128'(1'b0), 128'(botOutAvailable));
        checkValue("full", 128'(1'b0), 128'(full));
        checkValue("almostFull", 128'(1'b0), 128'(almostFull));
        checkValue("cfgAck", 128'(1'b0), 128'(cfgAck));

        // latency into an empty system is two edges
        driveRow(vecTable[0]);
        checkValue("early output", 128'(1'b0), 128'(botOutAvailable));
        stepCycle();
        checkValue("latency", 128'(1'b1), 128'(botOutAvailable));
        waitDrained();
        for (int i = 1; i < randomStart; i++) begin
            driveRow(vecTable[i]);
        end
        waitDrained();

        randomStalls = 1'b1;
        for (int i = randomStart; i < numRows; i++) begin
            driveRow(vecTable[i]);
        end
        waitDrained();
        randomStalls = 1'b0;

        curTest = "fullFlags";
        cfgWrite(cfgAlmostFull, 8'd6);
        holdStall = 1'b1;
        for (int k = 1; k <= depth + 1; k++) begin
            botA     = expandBot(32'h4000 + k);
            botIndex = 12'(k);
            validA   = 1'b1;
            dataRequested = 1'b0;
            queueEntry(botA, botIndex, 1'b1, 1'b0, 1'b0);
            stepCycle();
            checkValue("almostFull", 128'(k >= 7), 128'(almostFull));   // one sits in the slot
            checkValue("full", 128'(k >= depth + 1), 128'(full));
        end
        holdStall = 1'b0;
        waitDrained();

        curTest = "alternate";
        cfgWrite(cfgSchedMode, 8'd1);
        holdStall = 1'b1;
        for (int k = 0; k < 6; k++) begin
            botA     = expandBot(32'h7000 + k);
            botC     = expandBot(32'h7100 + k);
            botIndex = 12'(k + 'h500);
            {validA, validB, validC, validD} = (k < 3) ? 4'b1111 : 4'b0011;   // CD gets more
            dataRequested = 1'b0;
            queueEntry(botA, botIndex, validA, validB, 1'b0);
            queueEntry(botC, botIndex, 1'b1, 1'b1, 1'b1);
            stepCycle();
        end
        altRecord = 1'b1;
        holdStall = 1'b0;
        waitDrained();
        altRecord = 1'b0;
        if (altSeq.size() != 9) begin
            errorCount++;
            $display("alternate: saw %0d entries instead of 9", altSeq.size());
        end
        // CD first after the all-AB fill then strict turns until AB runs dry
        for (int i = 0; i < altSeq.size(); i++) begin
            checkValue("fromCD", 128'((i % 2 == 0) || (i > 6)), 128'(altSeq[i]));
        end

        $display("checks done, errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
